// ==== floo_vc_sa.f ====
+incdir+tests
verilog/floo_sa_pkg.sv
verilog/floo_rr_arbiter.sv
verilog/floo_sa_local.sv
verilog/floo_sa_global.sv
verilog/floo_vc_sa.sv
tests/floo_vc_sa_tb.sv

// ==== tests/floo_vc_sa_tb_table.svh ====
// stimulus and expected rows for the switch allocator testbench
// columns: head_v, dir, head_last, out_ready, vc_pop, winners,
// out_valid, out_last
// head_v, head_last and vc_pop hold one vc mask digit per input;
// dir holds the direction of each input, winners the input per output

task automatic load_rows();
  // reset state, nothing valid so every output is low
  add_row(20'h00000, 20'h00000, 20'h00000, 5'b11111,
          20'h00000, 20'hfffff, 5'b00000, 5'b00000);
  // inputs 0 and 2 to south, index 0 wins locally and globally
  add_row(20'h00909, 20'h00202, 20'h00909, 5'b11111,
          20'h00001, 20'hff0ff, 5'b00100, 5'b00100);

  // input 1, four single-flit vcs to east, pops rotate over the vcs
  add_row(20'h000f0, 20'h00010, 20'h000f0, 5'b11111,
          20'h00010, 20'hfff1f, 5'b00010, 5'b00010);
  add_row(20'h000f0, 20'h00010, 20'h000f0, 5'b11111,
          20'h00020, 20'hfff1f, 5'b00010, 5'b00010);
  add_row(20'h000f0, 20'h00010, 20'h000f0, 5'b11111,
          20'h00040, 20'hfff1f, 5'b00010, 5'b00010);
  add_row(20'h000f0, 20'h00010, 20'h000f0, 5'b11111,
          20'h00080, 20'hfff1f, 5'b00010, 5'b00010);
  // wraps back to vc0
  add_row(20'h000f0, 20'h00010, 20'h000f0, 5'b11111,
          20'h00010, 20'hfff1f, 5'b00010, 5'b00010);

  // inputs 0, 2 and 3 to eject, the output rotates in input order
  add_row(20'h04102, 20'h04404, 20'h04102, 5'b11111,
          20'h00002, 20'h0ffff, 5'b10000, 5'b10000);
  add_row(20'h04102, 20'h04404, 20'h04102, 5'b11111,
          20'h00100, 20'h2ffff, 5'b10000, 5'b10000);
  add_row(20'h04102, 20'h04404, 20'h04102, 5'b11111,
          20'h04000, 20'h3ffff, 5'b10000, 5'b10000);
  add_row(20'h04102, 20'h04404, 20'h04102, 5'b11111,
          20'h00002, 20'h0ffff, 5'b10000, 5'b10000);

  // wormhole, head flit of input 0 vc1 to north beats input 2
  add_row(20'h00102, 20'h00000, 20'h00100, 5'b11111,
          20'h00002, 20'hffff0, 5'b00001, 5'b00000);
  // body flit, other vcs with tail bits set stay locked out
  add_row(20'h0010f, 20'h00000, 20'h0010d, 5'b11111,
          20'h00002, 20'hffff0, 5'b00001, 5'b00000);
  // bubble in the packet, north grants nobody
  add_row(20'h0010d, 20'h00000, 20'h0010d, 5'b11111,
          20'h00000, 20'hfffff, 5'b00000, 5'b00000);
  // tail flit releases both locks
  add_row(20'h0010f, 20'h00000, 20'h0010f, 5'b11111,
          20'h00002, 20'hffff0, 5'b00001, 5'b00001);
  // north moved on to input 2
  add_row(20'h0010d, 20'h00000, 20'h0010d, 5'b11111,
          20'h00100, 20'hffff2, 5'b00001, 5'b00001);

  // inputs 1 and 4 to west while west is stalled
  add_row(20'h90020, 20'h30030, 20'h90020, 5'b10111,
          20'h00000, 20'hf1fff, 5'b01000, 5'b01000);
  add_row(20'h90020, 20'h30030, 20'h90020, 5'b10111,
          20'h00000, 20'hf1fff, 5'b01000, 5'b01000);
  // ready again, same winner pops
  add_row(20'h90020, 20'h30030, 20'h90020, 5'b11111,
          20'h00020, 20'hf1fff, 5'b01000, 5'b01000);
  add_row(20'h90000, 20'h30000, 20'h90000, 5'b11111,
          20'h10000, 20'hf4fff, 5'b01000, 5'b01000);

  // five inputs to five distinct outputs, all pop together
  add_row(20'h18285, 20'h04321, 20'h18285, 5'b11111,
          20'h18284, 20'h32104, 5'b11111, 5'b11111);
  // idle again
  add_row(20'h00000, 20'h00000, 20'h00000, 5'b11111,
          20'h00000, 20'hfffff, 5'b00000, 5'b00000);
endtask

// ==== tests/floo_vc_sa_tb.sv ====
// testbench for the vc switch allocator
// applies a hand-derived table of head states and output ready levels,
// one row per clock cycle, and checks pops, crossbar selects, valid
// and last bits of every output against the expected columns
`default_nettype none

module floo_vc_sa_tb;

  import floo_sa_pkg::*;

  localparam int ClkPeriod    = 100;
  localparam int ResetCycles  = 8;
  // cycles allowed for the reset release
  localparam int ResetTimeout = 20;

  logic                                 clk;
  logic                                 arst_n;
  logic       [NumPorts-1:0][NumVC-1:0] head_v;
  route_dir_e [NumPorts-1:0][NumVC-1:0] head_dir;
  logic       [NumPorts-1:0][NumVC-1:0] head_last;
  logic       [NumPorts-1:0]            out_ready;
  logic    [NumPorts-1:0][NumVC-1:0]    vc_pop;
  logic    [NumPorts-1:0][NumPorts-1:0] xbar_sel;
  logic    [NumPorts-1:0]               out_valid;
  logic    [NumPorts-1:0]               out_last;

  // table columns with one entry per row
  // per-input words carry one hex digit per input with input 0 lowest
  logic [19:0] row_v[$];
  logic [19:0] row_dir[$];
  logic [19:0] row_last[$];
  logic [4:0]  row_rdy[$];
  logic [19:0] row_pop[$];
  // winning input per output as one hex digit and f for none
  logic [19:0] row_win[$];
  logic [4:0]  row_valid[$];
  logic [4:0]  row_lst[$];

  int cur_row;
  int wait_cycles;

  floo_vc_sa u_floo_vc_sa (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .head_v_i    (head_v),
    .head_dir_i  (head_dir),
    .head_last_i (head_last),
    .out_ready_i (out_ready),
    .vc_pop_o    (vc_pop),
    .xbar_sel_o  (xbar_sel),
    .out_valid_o (out_valid),
    .out_last_o  (out_last)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // reset held over the first rising edges and released on a falling edge
  initial begin : reset_gen
    arst_n = 1'b0;
    repeat (ResetCycles) @(negedge clk);
    arst_n = 1'b1;
  end

  task automatic add_row(input logic [19:0] v, input logic [19:0] dir,
                         input logic [19:0] last, input logic [4:0] rdy,
                         input logic [19:0] pop, input logic [19:0] win,
                         input logic [4:0] valid, input logic [4:0] lst);
    row_v.push_back(v);
    row_dir.push_back(dir);
    row_last.push_back(last);
    row_rdy.push_back(rdy);
    row_pop.push_back(pop);
    row_win.push_back(win);
    row_valid.push_back(valid);
    row_lst.push_back(lst);
  endtask

  `include "floo_vc_sa_tb_table.svh"

  // expand winner digits into the one-hot crossbar columns
  function automatic logic [24:0] sel_from_winners(input logic [19:0] win);
    logic [24:0] sel;
    logic [3:0]  idx;
    sel = '0;
    for (int o = 0; o < NumPorts; o++) begin
      idx = win[o*4 +: 4];
      if (idx != 4'hf) begin
        sel[o*NumPorts + idx] = 1'b1;
      end
    end
    return sel;
  endfunction

  // valid vcs take the direction digit of their input
  // idle vcs point one port further on, so a wrong vc select
  // shows up as a request on another output
  task automatic drive_row(input int r);
    logic [2:0] dir;
    head_v    = row_v[r];
    head_last = row_last[r];
    out_ready = row_rdy[r];
    for (int p = 0; p < NumPorts; p++) begin
      dir = row_dir[r][p*4 +: 3];
      for (int v = 0; v < NumVC; v++) begin
        if (row_v[r][p*4 + v]) begin
          head_dir[p][v] = route_dir_e'(dir);
        end else begin
          head_dir[p][v] = route_dir_e'((dir == 3'd4) ? 3'd0 : dir + 3'd1);
        end
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    if (got !== exp) begin
      $display("FAIL %s exp %h got %h in row %0d", name, exp, got, cur_row);
      $display("Verification failed");
      $fatal(1, "output mismatch against the table");
    end
  endtask

  initial begin
    clk       = 1'b0;
    head_v    = '0;
    head_last = '0;
    out_ready = '0;
    cur_row   = 0;
    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVC; v++) begin
        head_dir[p][v] = DirNorth;
      end
    end
    load_rows();

    // bounded wait for reset release
    wait_cycles = 0;
    while (arst_n !== 1'b1) begin
      if (wait_cycles == ResetTimeout) begin
        $display("reset was not released within %0d cycles", ResetTimeout);
        $display("Verification failed");
        $fatal(1, "reset timeout");
      end
      @(negedge clk);
      wait_cycles++;
    end

    // drive on the falling edge and sample halfway to the rising edge
    for (int r = 0; r < row_v.size(); r++) begin
      @(negedge clk);
      cur_row = r;
      drive_row(r);
      #(ClkPeriod / 4);
      check_value("vc_pop_o", row_pop[r], vc_pop);
      check_value("xbar_sel_o", sel_from_winners(row_win[r]), xbar_sel);
      check_value("out_valid_o", row_valid[r], out_valid);
      check_value("out_last_o", row_lst[r], out_last);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/floo_rr_arbiter.sv ====
// round-robin arbiter
// grants the first requester at or after a one-hot priority pointer,
// wrapping past the top; the pointer only moves on update_i and then
// parks one place above the current winner
`default_nettype none

module floo_rr_arbiter #(
  parameter int NumInputs = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [NumInputs-1:0] req_i,
  input  logic                 update_i,
  output logic [NumInputs-1:0] grant_o
);

  // one-hot pointer to the input with highest priority
  logic [NumInputs-1:0] prio_q;
  // thermometer built from the pointer with ones at and above it
  logic [NumInputs-1:0] prio_mask;
  // requests that sit at or above the pointer
  logic [NumInputs-1:0] req_masked;
  // request vector the lowest-bit search runs on
  logic [NumInputs-1:0] req_pick;

  // prefix or of the one-hot pointer
  always_comb begin
    prio_mask[0] = prio_q[0];
    for (int i = 1; i < NumInputs; i++) begin
      prio_mask[i] = prio_mask[i-1] | prio_q[i];
    end
  end

  assign req_masked = req_i & prio_mask;

  // nobody above the pointer so wrap around to index 0
  assign req_pick = (|req_masked) ? req_masked : req_i;

  // lowest set bit wins and nobody wins without requests
  assign grant_o = req_pick & (~req_pick + 1'b1);

  // winner drops to lowest priority
  // a strobe with no grant leaves the pointer alone
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q <= NumInputs'(1);
    end else if (update_i && (|grant_o)) begin
      prio_q <= {grant_o[NumInputs-2:0], grant_o[NumInputs-1]};
    end
  end

  // grant is a single requester or nobody
  a_grant_legal: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(grant_o) && ((grant_o & ~req_i) == '0)
  ) else $error("rr arbiter grant not one-hot or not requested");

endmodule

`default_nettype wire

// ==== verilog/floo_sa_global.sv ====
// switch allocator global stage
// picks one requesting input port for one output by round-robin
// and drives the crossbar select; the output stays with that input
// until the tail flit of its packet has crossed
`default_nettype none

module floo_sa_global (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic [floo_sa_pkg::NumPorts-1:0]   req_i,
  input  logic [floo_sa_pkg::NumPorts-1:0]   req_last_i,
  input  logic                               out_ready_i,
  output logic [floo_sa_pkg::NumPorts-1:0]   gnt_in_oh_o,
  output logic                               out_valid_o,
  output logic                               out_last_o
);

  import floo_sa_pkg::*;

  // output reserved for input lock_in_q
  logic                lock_q;
  logic [NumPorts-1:0] lock_in_q;
  logic [NumPorts-1:0] arb_req;
  // flit crosses this cycle
  logic                fire;
  logic                arb_update;

  // a reserved output only listens to its owner
  assign arb_req = lock_q ? (req_i & lock_in_q) : req_i;

  floo_rr_arbiter #(
    .NumInputs (NumPorts)
  ) u_in_arb (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (arb_req),
    .update_i (arb_update),
    .grant_o  (gnt_in_oh_o)
  );

  // shown even under back-pressure
  assign out_valid_o = |gnt_in_oh_o;

  // tail bit of the winning input
  assign out_last_o = |(gnt_in_oh_o & req_last_i);

  assign fire = out_valid_o & out_ready_i;

  // pointer moves after the tail only
  assign arb_update = fire & out_last_o;

  // reserve on a body flit, free on the tail
  // nothing changes while the output is stalled
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q    <= 1'b0;
      lock_in_q <= '0;
    end else if (fire) begin
      lock_q    <= !out_last_o;
      lock_in_q <= gnt_in_oh_o;
    end
  end

  // valid flags exactly the cycles with a crossbar select
  a_valid_matches_grant: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o == (|gnt_in_oh_o)
  ) else $error("global stage valid disagrees with grant");

endmodule

`default_nettype wire

// ==== verilog/floo_sa_local.sv ====
// switch allocator local stage
// picks a valid vc head of one input port by round-robin, muxes its
// direction and last bit and raises the matching output request
// and holds the vc for the whole wormhole packet
`default_nettype none

module floo_sa_local (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  logic                    [floo_sa_pkg::NumVC-1:0] vc_head_v_i,
  input  floo_sa_pkg::route_dir_e [floo_sa_pkg::NumVC-1:0] vc_head_dir_i,
  input  logic                    [floo_sa_pkg::NumVC-1:0] vc_head_last_i,
  input  logic                                             sent_i,
  output logic                    [floo_sa_pkg::NumVC-1:0] vc_id_oh_o,
  output logic                                             sel_last_o,
  output logic                 [floo_sa_pkg::NumPorts-1:0] output_dir_oh_o
);

  import floo_sa_pkg::*;

  // packet in flight on lock_vc_q
  logic                lock_q;
  logic [NumVC-1:0]    lock_vc_q;
  // requests seen by the arbiter
  logic [NumVC-1:0]    arb_req;
  // direction of the chosen head
  logic [DirWidth-1:0] sel_dir;
  logic                sel_v;
  logic                arb_update;

  // during a packet only the owning vc may compete
  assign arb_req = lock_q ? (vc_head_v_i & lock_vc_q) : vc_head_v_i;

  // wormhole priority moves only once the tail has left
  assign arb_update = sent_i & sel_last_o;

  floo_rr_arbiter #(
    .NumInputs (NumVC)
  ) u_vc_arb (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (arb_req),
    .update_i (arb_update),
    .grant_o  (vc_id_oh_o)
  );

  // and-or mux of the winning head since the grant is one-hot or zero
  always_comb begin
    sel_dir    = '0;
    sel_last_o = 1'b0;
    for (int v = 0; v < NumVC; v++) begin
      sel_dir    = sel_dir | (vc_head_dir_i[v] & {DirWidth{vc_id_oh_o[v]}});
      sel_last_o = sel_last_o | (vc_head_last_i[v] & vc_id_oh_o[v]);
    end
  end

  assign sel_v = |vc_id_oh_o;

  // one request line towards the chosen output, none when idle
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      output_dir_oh_o[o] = sel_v && (sel_dir == DirWidth'(o));
    end
  end

  // lock on a body flit, release on the tail
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q    <= 1'b0;
      lock_vc_q <= '0;
    end else if (sent_i) begin
      lock_q    <= !sel_last_o;
      lock_vc_q <= vc_id_oh_o;
    end
  end

  // a held packet belongs to exactly one vc
  a_lock_one_vc: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    lock_q |-> $onehot(lock_vc_q)
  ) else $error("local stage locked on no vc or on several vcs");

endmodule

`default_nettype wire

// ==== verilog/floo_sa_pkg.sv ====
// switch allocator package
// port and vc counts of the five-port wormhole router, and the
// lookahead route direction that names each output port
`default_nettype none

package floo_sa_pkg;

  // virtual channels behind every input port
  localparam int NumVC = 4;

  // router ports, four mesh neighbours plus the local eject
  localparam int NumPorts = 5;

  // bits needed to encode one output direction
  localparam int DirWidth = 3;

  // lookahead direction carried by every head flit
  // encoding doubles as the output port index
  typedef enum logic [DirWidth-1:0] {
    DirNorth = 3'd0,
    DirEast  = 3'd1,
    DirSouth = 3'd2,
    DirWest  = 3'd3,
    // local endpoint
    DirEject = 3'd4
  } route_dir_e;

endpackage

`default_nettype wire

// ==== verilog/floo_vc_sa.sv ====
// vc switch allocator top
// five local stages choose a vc per input, five global stages choose
// an input per output; the grants become crossbar selects and, where
// the output is ready, vc pops
`default_nettype none

module floo_vc_sa (
  input  logic                                                             clk_i,
  input  logic                                                             arst_n_i,
  input  logic    [floo_sa_pkg::NumPorts-1:0][floo_sa_pkg::NumVC-1:0]     head_v_i,
  input  floo_sa_pkg::route_dir_e
                  [floo_sa_pkg::NumPorts-1:0][floo_sa_pkg::NumVC-1:0]     head_dir_i,
  input  logic    [floo_sa_pkg::NumPorts-1:0][floo_sa_pkg::NumVC-1:0]     head_last_i,
  input  logic    [floo_sa_pkg::NumPorts-1:0]                             out_ready_i,
  output logic    [floo_sa_pkg::NumPorts-1:0][floo_sa_pkg::NumVC-1:0]     vc_pop_o,
  output logic    [floo_sa_pkg::NumPorts-1:0][floo_sa_pkg::NumPorts-1:0]  xbar_sel_o,
  output logic    [floo_sa_pkg::NumPorts-1:0]                             out_valid_o,
  output logic    [floo_sa_pkg::NumPorts-1:0]                             out_last_o
);

  import floo_sa_pkg::*;

  // local results, indexed [input]
  logic [NumPorts-1:0][NumPorts-1:0] loc_dir_oh;
  logic [NumPorts-1:0][NumVC-1:0]    loc_vc_oh;
  logic [NumPorts-1:0]               loc_last;
  // requests seen by each output, indexed [output][input]
  logic [NumPorts-1:0][NumPorts-1:0] glb_req;
  // global grants, indexed [output][input]
  logic [NumPorts-1:0][NumPorts-1:0] gnt_in_oh;
  // same grants seen from the input side, [input][output]
  logic [NumPorts-1:0][NumPorts-1:0] gnt_by_out;
  // input p had a flit cross its output this cycle
  logic [NumPorts-1:0]               sent;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_in
    floo_sa_local u_local (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .vc_head_v_i     (head_v_i[p]),
      .vc_head_dir_i   (head_dir_i[p]),
      .vc_head_last_i  (head_last_i[p]),
      .sent_i          (sent[p]),
      .vc_id_oh_o      (loc_vc_oh[p]),
      .sel_last_o      (loc_last[p]),
      .output_dir_oh_o (loc_dir_oh[p])
    );

    // transpose both ways between input and output view
    for (genvar o = 0; o < NumPorts; o++) begin : gen_xpose
      assign glb_req[o][p]    = loc_dir_oh[p][o];
      assign gnt_by_out[p][o] = gnt_in_oh[o][p];
    end

    // a local request targets one output at most,
    // so at most one output can have granted it
    assign sent[p] = |(gnt_by_out[p] & out_ready_i);

    // pop only what actually left
    assign vc_pop_o[p] = loc_vc_oh[p] & {NumVC{sent[p]}};

    // one local request per input means one grant at most
    a_single_grant: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(gnt_by_out[p])
    ) else $error("input %0d granted by two outputs", p);
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    // tail bits come straight from the locals, same for every output
    floo_sa_global u_global (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_i       (glb_req[o]),
      .req_last_i  (loc_last),
      .out_ready_i (out_ready_i[o]),
      .gnt_in_oh_o (gnt_in_oh[o]),
      .out_valid_o (out_valid_o[o]),
      .out_last_o  (out_last_o[o])
    );

    // crossbar column select is the global grant itself
    assign xbar_sel_o[o] = gnt_in_oh[o];
  end

endmodule

`default_nettype wire
